//--- verilog/core_cfg_pkg.sv
package core_cfg_pkg;

    // instruction and address widths
    localparam int INST_ADDR_WIDTH = 32;
    localparam int INST_WIDTH      = 32;
    localparam int INST_BYTES      = INST_WIDTH / 8;
    localparam int REG_ADDR_WIDTH  = 5;
    // jal immediate incl. implied zero lsb
    localparam int JAL_OFF_WIDTH   = 21;

    // two sequential words per fetch
    localparam int NUM_LANES = 2;
    localparam logic [INST_ADDR_WIDTH-1:0] FETCH_STRIDE =
        INST_ADDR_WIDTH'(NUM_LANES * INST_BYTES);

    // start address and interrupt target
    localparam logic [INST_ADDR_WIDTH-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [INST_ADDR_WIDTH-1:0] TRAP_VEC = 32'h0000_0100;

    // per-stage control bus layout
    localparam int CU_BUS_WIDTH      = 3;
    localparam int CU_STALL          = 0;
    localparam int CU_FLUSH          = 1;
    localparam int CU_STALL_DISPATCH = 2;

    // M extension marker in funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b000_0001;

    // multi-cycle occupancy
    localparam int MULDIV_CYCLES   = 4;
    localparam int AMO_BUSY_CYCLES = 2;
    localparam int MD_CNT_WIDTH    = $clog2(MULDIV_CYCLES);
    localparam int AMO_CNT_WIDTH   = $clog2(AMO_BUSY_CYCLES + 1);

endpackage

//--- verilog/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    import core_cfg_pkg::*;

    // execution class after decode
    typedef enum logic [2:0] {
        OP_NOP,
        OP_ALU,
        OP_JAL,
        OP_MULDIV,
        OP_AMO
    } op_class_e;

    // bit k set means lane k issues
    typedef enum logic [1:0] {
        ISSUE_NONE  = 2'b00,
        ISSUE_LANE0 = 2'b01,
        ISSUE_LANE1 = 2'b10,
        ISSUE_BOTH  = 2'b11
    } issue_e;

    // rv32 major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_OP     = 7'b011_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_JAL    = 7'b110_1111,
        OPC_AMO    = 7'b010_1111
    } rv_opcode_e;

    typedef struct packed {
        logic                       valid;
        logic [INST_ADDR_WIDTH-1:0] pc;
        logic [INST_WIDTH-1:0]      inst;
    } fetch_pkt_t;

    typedef struct packed {
        logic                      valid;
        logic [INST_ADDR_WIDTH-1:0] pc;
        op_class_e                 op;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic                      writes_rd;
        logic [JAL_OFF_WIDTH-1:0]  jal_off;
    } dec_inst_t;

    // msb first, so stall lands on bit CU_STALL
    typedef struct packed {
        logic stall_dispatch;
        logic flush;
        logic stall;
    } stage_ctrl_t;

    typedef struct packed {
        logic                       valid;
        logic [INST_ADDR_WIDTH-1:0] pc;
        op_class_e                  op;
    } retire_t;

endpackage

//--- verilog/ifu.sv
`timescale 1ns/1ps

module ifu (
    input  logic clk,
    input  logic rst_i,

    // from ctrl
    input  pipe_ctrl_pkg::stage_ctrl_t                     fetch_ctrl_i,
    input  logic                                           jump_flag_i,
    input  logic [core_cfg_pkg::INST_ADDR_WIDTH-1:0]       jump_addr_i,

    // interrupt redirect
    input  logic                                           irq_i,

    // instruction memory
    output logic [core_cfg_pkg::INST_ADDR_WIDTH-1:0]       fetch_addr_o,
    input  logic [core_cfg_pkg::NUM_LANES*core_cfg_pkg::INST_WIDTH-1:0] fetch_data_i,

    // to decode lanes
    output pipe_ctrl_pkg::fetch_pkt_t fetch_pkt_o [core_cfg_pkg::NUM_LANES]
);

    import core_cfg_pkg::*;

    logic [INST_ADDR_WIDTH-1:0] pc_q;

    // pc update
    // irq beats jump, jump beats stall
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (irq_i) begin
            pc_q <= TRAP_VEC;
        end else if (jump_flag_i) begin
            pc_q <= jump_addr_i;
        end else if (!fetch_ctrl_i.stall) begin
            pc_q <= pc_q + FETCH_STRIDE;
        end
    end

    assign fetch_addr_o = pc_q;

    // split fetch word, lane k gets word k
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            // flushed fetch is dropped, redirect target comes next cycle
            fetch_pkt_o[k].valid = ~fetch_ctrl_i.flush;
            fetch_pkt_o[k].pc    = pc_q + INST_ADDR_WIDTH'(k * INST_BYTES);
            fetch_pkt_o[k].inst  = fetch_data_i[k*INST_WIDTH +: INST_WIDTH];
        end
    end

endmodule

//--- verilog/id_lane.sv
`timescale 1ns/1ps

module id_lane (
    input  logic clk,
    input  logic rst_i,

    // from ctrl
    input  pipe_ctrl_pkg::stage_ctrl_t lane_ctrl_i,

    // from ifu
    input  pipe_ctrl_pkg::fetch_pkt_t  fetch_pkt_i,

    // to hdu and ex
    output pipe_ctrl_pkg::dec_inst_t   dec_o
);

    import core_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    fetch_pkt_t pkt_q;
    rv_opcode_e opcode;
    logic [6:0] funct7;

    // lane register
    // flush wins over stall, payload only moves on load
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pkt_q.valid <= 1'b0;
        end else if (lane_ctrl_i.flush) begin
            pkt_q.valid <= 1'b0;
        end else if (!lane_ctrl_i.stall) begin
            pkt_q <= fetch_pkt_i;
        end
    end

    // field decode
    always_comb begin
        opcode = rv_opcode_e'(pkt_q.inst[6:0]);
        funct7 = pkt_q.inst[31:25];

        dec_o.valid = pkt_q.valid;
        dec_o.pc    = pkt_q.pc;
        dec_o.rd    = pkt_q.inst[11:7];
        // source fields only where the format has them
        dec_o.rs1   = '0;
        dec_o.rs2   = '0;
        // j-type immediate, lsb always zero
        dec_o.jal_off = {pkt_q.inst[31], pkt_q.inst[19:12], pkt_q.inst[20],
                         pkt_q.inst[30:21], 1'b0};

        case (opcode)
            OPC_OP: begin
                dec_o.op  = (funct7 == FUNCT7_MULDIV) ? OP_MULDIV : OP_ALU;
                dec_o.rs1 = pkt_q.inst[19:15];
                dec_o.rs2 = pkt_q.inst[24:20];
            end
            OPC_OP_IMM: begin
                dec_o.op  = OP_ALU;
                dec_o.rs1 = pkt_q.inst[19:15];
            end
            // upper immediates read no register
            OPC_LUI, OPC_AUIPC: begin
                dec_o.op = OP_ALU;
            end
            OPC_JAL: begin
                dec_o.op = OP_JAL;
            end
            // address in rs1, store data in rs2
            OPC_AMO: begin
                dec_o.op  = OP_AMO;
                dec_o.rs1 = pkt_q.inst[19:15];
                dec_o.rs2 = pkt_q.inst[24:20];
            end
            default: begin
                dec_o.op = OP_NOP;
            end
        endcase

        // x0 is never a real destination
        dec_o.writes_rd = (dec_o.op != OP_NOP) && (dec_o.rd != '0);
    end

endmodule

//--- verilog/hdu.sv
`timescale 1ns/1ps

module hdu (
    // from decode lanes
    input  pipe_ctrl_pkg::dec_inst_t dec_i [core_cfg_pkg::NUM_LANES],

    // from ex
    input  logic                     amo_busy_i,

    // to ctrl
    output pipe_ctrl_pkg::issue_e    issue_o
);

    import pipe_ctrl_pkg::*;

    logic lane0_vld;
    logic lane1_vld;
    logic lane0_serial;
    logic lane1_serial;
    logic raw_dep;
    logic amo_block;

    assign lane0_vld = dec_i[0].valid;
    assign lane1_vld = dec_i[1].valid;

    // classes that must go through execute alone
    assign lane0_serial = lane0_vld && (dec_i[0].op inside {OP_JAL, OP_MULDIV, OP_AMO});
    assign lane1_serial = lane1_vld && (dec_i[1].op inside {OP_JAL, OP_MULDIV, OP_AMO});

    // lane 1 source matches lane 0 destination
    assign raw_dep = lane0_vld && lane1_vld && dec_i[0].writes_rd &&
                     ((dec_i[1].rs1 == dec_i[0].rd) || (dec_i[1].rs2 == dec_i[0].rd));

    // oldest waiting instruction is an amo while the last one is still busy
    // lane 1 counts as oldest once lane 0 has drained
    assign amo_block = amo_busy_i &&
                       ((lane0_vld && (dec_i[0].op == OP_AMO)) ||
                        (!lane0_vld && lane1_vld && (dec_i[1].op == OP_AMO)));

    // first matching rule wins
    always_comb begin
        if (amo_block) begin
            issue_o = ISSUE_NONE;
        end else if (!lane0_vld && lane1_vld) begin
            // leftover lane 1 after a single issue
            issue_o = ISSUE_LANE1;
        end else if (raw_dep || lane0_serial || lane1_serial) begin
            issue_o = ISSUE_LANE0;
        end else begin
            // also taken with both lanes empty so fetch keeps moving
            issue_o = ISSUE_BOTH;
        end
    end

endmodule

//--- verilog/ctrl.sv
`timescale 1ns/1ps

module ctrl (
    // from ex
    input  logic                                     jump_flag_i,
    input  logic [core_cfg_pkg::INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  logic                                     stall_flag_ex_i,

    // interrupt flush
    input  logic                                     flush_flag_clint_i,

    // from hdu
    input  pipe_ctrl_pkg::issue_e                    issue_inst_hdu_i,

    // fetch, lane 0, lane 1
    output pipe_ctrl_pkg::stage_ctrl_t               stall_flag_o,
    output pipe_ctrl_pkg::stage_ctrl_t               stall_flag1_o,
    output pipe_ctrl_pkg::stage_ctrl_t               stall_flag2_o,

    // to ifu
    output logic                                     jump_flag_o,
    output logic [core_cfg_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o
);

    import core_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    logic stall_hdu_if;
    logic stall_hdu_id1;
    logic stall_hdu_id2;
    logic flush_hdu_id1;
    logic flush_hdu_id2;
    logic redirect;
    logic dispatch_block;

    logic [CU_BUS_WIDTH-1:0] if_bus;
    logic [CU_BUS_WIDTH-1:0] id1_bus;
    logic [CU_BUS_WIDTH-1:0] id2_bus;

    // issue code to per-stage hold and drain
    // an issued lane is flushed, a waiting lane held
    always_comb begin
        stall_hdu_if  = 1'b0;
        stall_hdu_id1 = 1'b0;
        stall_hdu_id2 = 1'b0;
        flush_hdu_id1 = 1'b0;
        flush_hdu_id2 = 1'b0;
        case (issue_inst_hdu_i)
            ISSUE_NONE: begin
                stall_hdu_if  = 1'b1;
                stall_hdu_id1 = 1'b1;
                stall_hdu_id2 = 1'b1;
            end
            ISSUE_LANE0: begin
                stall_hdu_if  = 1'b1;
                stall_hdu_id2 = 1'b1;
                flush_hdu_id1 = 1'b1;
            end
            ISSUE_LANE1: begin
                stall_hdu_if  = 1'b1;
                stall_hdu_id1 = 1'b1;
                flush_hdu_id2 = 1'b1;
            end
            ISSUE_BOTH: begin
                stall_hdu_if  = 1'b0;
            end
            default: begin
                stall_hdu_if  = 1'b1;
            end
        endcase
    end

    // no redirect while a muldiv holds execute
    assign jump_addr_o = jump_addr_i;
    assign jump_flag_o = jump_flag_i & ~stall_flag_ex_i;

    // jump or interrupt drains fetch and both lanes
    assign redirect = jump_flag_o | flush_flag_clint_i;

    // nothing enters execute while it is busy or the lanes are being dropped
    assign dispatch_block = stall_flag_ex_i | redirect;

    assign if_bus[CU_STALL]          = stall_flag_ex_i | (stall_hdu_if & ~jump_flag_i);
    assign if_bus[CU_FLUSH]          = redirect;
    assign if_bus[CU_STALL_DISPATCH] = dispatch_block;

    // issue flush only counts when the lane really moved into execute
    assign id1_bus[CU_STALL]          = stall_flag_ex_i | (stall_hdu_id1 & ~jump_flag_i);
    assign id1_bus[CU_FLUSH]          = redirect | (flush_hdu_id1 & ~stall_flag_ex_i);
    assign id1_bus[CU_STALL_DISPATCH] = dispatch_block;

    assign id2_bus[CU_STALL]          = stall_flag_ex_i | (stall_hdu_id2 & ~jump_flag_i);
    assign id2_bus[CU_FLUSH]          = redirect | (flush_hdu_id2 & ~stall_flag_ex_i);
    assign id2_bus[CU_STALL_DISPATCH] = dispatch_block;

    assign stall_flag_o  = stage_ctrl_t'(if_bus);
    assign stall_flag1_o = stage_ctrl_t'(id1_bus);
    assign stall_flag2_o = stage_ctrl_t'(id2_bus);

endmodule

//--- verilog/ex_unit.sv
`timescale 1ns/1ps

module ex_unit (
    input  logic clk,
    input  logic rst_i,

    // from decode lanes and ctrl
    input  pipe_ctrl_pkg::dec_inst_t   dec_i       [core_cfg_pkg::NUM_LANES],
    input  pipe_ctrl_pkg::stage_ctrl_t lane_ctrl_i [core_cfg_pkg::NUM_LANES],

    // to ctrl
    output logic                                     stall_ex_o,
    output logic                                     jump_req_o,
    output logic [core_cfg_pkg::INST_ADDR_WIDTH-1:0] jump_addr_o,

    // to hdu
    output logic                                     amo_busy_o,

    // retire records
    output pipe_ctrl_pkg::retire_t retire_o [core_cfg_pkg::NUM_LANES]
);

    import core_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    dec_inst_t               ex_q [NUM_LANES];
    logic [NUM_LANES-1:0]    take;
    logic                    md_enter;
    logic                    amo_enter;
    logic [MD_CNT_WIDTH-1:0]  md_cnt_q;
    logic [AMO_CNT_WIDTH-1:0] amo_cnt_q;

    // lanes released by ctrl this cycle
    always_comb begin
        md_enter  = 1'b0;
        amo_enter = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            take[k] = dec_i[k].valid & ~lane_ctrl_i[k].stall & ~lane_ctrl_i[k].stall_dispatch;
            if (take[k] && (dec_i[k].op == OP_MULDIV)) begin
                md_enter = 1'b1;
            end
            if (take[k] && (dec_i[k].op == OP_AMO)) begin
                amo_enter = 1'b1;
            end
        end
    end

    // execute slots, frozen while muldiv runs
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                ex_q[k].valid <= 1'b0;
            end
        end else if (!stall_ex_o) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                ex_q[k]       <= dec_i[k];
                ex_q[k].valid <= take[k];
            end
        end
    end

    // muldiv down-counter
    // loaded on entry, execute held until it reaches zero
    always_ff @(posedge clk) begin
        if (rst_i) begin
            md_cnt_q <= '0;
        end else if (md_enter) begin
            md_cnt_q <= MD_CNT_WIDTH'(MULDIV_CYCLES - 1);
        end else if (md_cnt_q != '0) begin
            md_cnt_q <= md_cnt_q - 1'b1;
        end
    end

    assign stall_ex_o = (md_cnt_q != '0);

    // amo busy window, runs free of the execute stall
    always_ff @(posedge clk) begin
        if (rst_i) begin
            amo_cnt_q <= '0;
        end else if (amo_enter) begin
            amo_cnt_q <= AMO_CNT_WIDTH'(AMO_BUSY_CYCLES);
        end else if (amo_cnt_q != '0) begin
            amo_cnt_q <= amo_cnt_q - 1'b1;
        end
    end

    assign amo_busy_o = (amo_cnt_q != '0);

    // jal target, jal always sits alone in execute
    always_comb begin
        jump_req_o  = 1'b0;
        jump_addr_o = '0;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (ex_q[k].valid && (ex_q[k].op == OP_JAL)) begin
                jump_req_o  = 1'b1;
                jump_addr_o = ex_q[k].pc +
                    {{(INST_ADDR_WIDTH-JAL_OFF_WIDTH){ex_q[k].jal_off[JAL_OFF_WIDTH-1]}},
                     ex_q[k].jal_off};
            end
        end
    end

    // retire once the slot is no longer held
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            retire_o[k].valid = ex_q[k].valid & ~stall_ex_o;
            retire_o[k].pc    = ex_q[k].pc;
            retire_o[k].op    = ex_q[k].op;
        end
    end

endmodule

//--- verilog/dual_issue_frontend.sv
`timescale 1ns/1ps

module dual_issue_frontend (
    input  logic clk,
    input  logic rst_i,
    input  logic irq_i,

    // instruction memory
    output logic [core_cfg_pkg::INST_ADDR_WIDTH-1:0] fetch_addr_o,
    input  logic [core_cfg_pkg::NUM_LANES*core_cfg_pkg::INST_WIDTH-1:0] fetch_data_i,

    // retire records
    output pipe_ctrl_pkg::retire_t retire_o [core_cfg_pkg::NUM_LANES]
);

    import core_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    // stage control from ctrl
    stage_ctrl_t fetch_ctrl;
    stage_ctrl_t lane_ctrl [NUM_LANES];

    // datapath between stages
    fetch_pkt_t  fetch_pkt [NUM_LANES];
    dec_inst_t   dec       [NUM_LANES];
    issue_e      issue;

    // ex to ctrl and hdu
    logic                       stall_ex;
    logic                       jump_req;
    logic [INST_ADDR_WIDTH-1:0] jump_req_addr;
    logic                       amo_busy;

    // ctrl to ifu
    logic                       jump_flag;
    logic [INST_ADDR_WIDTH-1:0] jump_addr;

    ifu u_ifu (
        .clk          (clk),
        .rst_i        (rst_i),
        .fetch_ctrl_i (fetch_ctrl),
        .jump_flag_i  (jump_flag),
        .jump_addr_i  (jump_addr),
        .irq_i        (irq_i),
        .fetch_addr_o (fetch_addr_o),
        .fetch_data_i (fetch_data_i),
        .fetch_pkt_o  (fetch_pkt)
    );

    // one decode lane per fetched word
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        id_lane u_id_lane (
            .clk         (clk),
            .rst_i       (rst_i),
            .lane_ctrl_i (lane_ctrl[k]),
            .fetch_pkt_i (fetch_pkt[k]),
            .dec_o       (dec[k])
        );
    end

    hdu u_hdu (
        .dec_i      (dec),
        .amo_busy_i (amo_busy),
        .issue_o    (issue)
    );

    // irq doubles as the interrupt flush
    ctrl u_ctrl (
        .jump_flag_i        (jump_req),
        .jump_addr_i        (jump_req_addr),
        .stall_flag_ex_i    (stall_ex),
        .flush_flag_clint_i (irq_i),
        .issue_inst_hdu_i   (issue),
        .stall_flag_o       (fetch_ctrl),
        .stall_flag1_o      (lane_ctrl[0]),
        .stall_flag2_o      (lane_ctrl[1]),
        .jump_flag_o        (jump_flag),
        .jump_addr_o        (jump_addr)
    );

    ex_unit u_ex_unit (
        .clk         (clk),
        .rst_i       (rst_i),
        .dec_i       (dec),
        .lane_ctrl_i (lane_ctrl),
        .stall_ex_o  (stall_ex),
        .jump_req_o  (jump_req),
        .jump_addr_o (jump_req_addr),
        .amo_busy_o  (amo_busy),
        .retire_o    (retire_o)
    );

endmodule

//--- tests/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;

    import core_cfg_pkg::*;
    import pipe_ctrl_pkg::*;

    logic clk;
    logic rst_i;
    logic irq_i;
    logic [INST_ADDR_WIDTH-1:0] fetch_addr_o;
    logic [NUM_LANES*INST_WIDTH-1:0] fetch_data_i;
    retire_t retire [NUM_LANES];

    // instruction rom, 128 words, indexed by word address
    logic [INST_WIDTH-1:0] rom [128];
    logic [6:0] rom_idx;

    // reference state for the retire stream
    logic [INST_ADDR_WIDTH-1:0] exp_q [$];
    logic [INST_ADDR_WIDTH-1:0] loop_pc;
    logic [INST_ADDR_WIDTH-1:0] pair_pcs [4] = '{32'h00, 32'h08, 32'h50, 32'h100};
    localparam logic [INST_ADDR_WIDTH-1:0] RAW_PC = 32'h10;
    int loop_hits = 0;
    int cyc = 0;
    int last_retire_cyc = -100;
    int last_amo_cyc = -100;
    bit started = 0;
    int unsigned seed;
    int unsigned irq_delay;

    dual_issue_frontend u_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .irq_i        (irq_i),
        .fetch_addr_o (fetch_addr_o),
        .fetch_data_i (fetch_data_i),
        .retire_o     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // two words per fetch, lane 0 gets the lower address
    assign rom_idx = fetch_addr_o[8:2];
    assign fetch_data_i = {rom[rom_idx + 7'd1], rom[rom_idx]};

    // rv32 encoders
    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        addi = {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b001_0011};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input int rd, input int rs1,
                                          input int rs2);
        rtype = {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b011_0011};
    endfunction

    function automatic logic [31:0] amoadd(input int rd, input int rs1, input int rs2);
        amoadd = {7'b000_0000, 5'(rs2), 5'(rs1), 3'b010, 5'(rd), 7'b010_1111};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        jal = {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b110_1111};
    endfunction

    // execution class of each retiring program word, from the listing below
    function automatic op_class_e op_at_pc(input logic [31:0] pc);
        case (pc)
            32'h18, 32'h108:                   op_at_pc = OP_MULDIV;
            32'h20, 32'h24:                    op_at_pc = OP_AMO;
            32'h28, 32'h44, 32'h58, 32'h110:   op_at_pc = OP_JAL;
            default:                           op_at_pc = OP_ALU;
        endcase
    endfunction

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("error at %0t: %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
        fail_run();
    endtask

    task automatic plain_error(input string what);
        $display("%s (at %0t)", what, $time);
        fail_run();
    endtask

    task automatic load_program();
        // fill decodes as nop, pattern from whole index
        for (int i = 0; i < 128; i++) begin
            rom[i] = {8'hee, 8'(i), 9'h0, 7'h00};
        end
        // independent alu pairs
        rom[0]  = addi(1, 0, 1);
        rom[1]  = addi(2, 0, 2);
        rom[2]  = addi(3, 0, 3);
        rom[3]  = addi(4, 0, 4);
        // lane 1 reads x5 from lane 0
        rom[4]  = addi(5, 0, 5);
        rom[5]  = rtype(7'b000_0000, 6, 5, 1);
        // mul in lane 0
        rom[6]  = rtype(FUNCT7_MULDIV, 7, 1, 2);
        rom[7]  = addi(8, 0, 8);
        // back to back amos
        rom[8]  = amoadd(9, 1, 2);
        rom[9]  = amoadd(10, 1, 2);
        // 0x28 jumps to 0x40, 0x2c..0x3c must never retire
        rom[10] = jal(0, 24);
        for (int i = 11; i < 16; i++) begin
            rom[i] = addi(15, 0, i);
        end
        // jal in lane 1, 0x48 and 0x4c skipped
        rom[16] = addi(12, 0, 1);
        rom[17] = jal(1, 12);
        rom[18] = addi(15, 0, 18);
        rom[19] = addi(15, 0, 19);
        rom[20] = addi(13, 0, 1);
        rom[21] = addi(14, 0, 1);
        // main program parks in a self loop
        rom[22] = jal(0, 0);
        rom[23] = addi(15, 0, 23);
        // trap handler at 0x100
        rom[64] = addi(16, 0, 1);
        rom[65] = addi(17, 0, 1);
        rom[66] = rtype(FUNCT7_MULDIV, 18, 16, 17);
        rom[67] = addi(19, 0, 1);
        rom[68] = jal(0, 0);
        rom[69] = addi(15, 0, 69);
    endtask

    // compare one retire against the in-order reference
    task automatic check_retire(input retire_t r);
        logic [31:0] exp;
        op_class_e   exp_op;
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
        end else begin
            exp = loop_pc;
            loop_hits++;
        end
        exp_op = op_at_pc(exp);
        assert (r.pc == exp) else value_error("retire_o.pc", exp, r.pc);
        assert (r.op == exp_op) else value_error("retire_o.op", 32'(exp_op), 32'(r.op));
        if (exp_op == OP_MULDIV) begin
            assert (cyc - last_retire_cyc >= MULDIV_CYCLES)
                else plain_error("another retire inside the muldiv window");
        end
        if (exp_op == OP_AMO) begin
            assert (cyc - last_amo_cyc > AMO_BUSY_CYCLES)
                else plain_error("amo retired inside the busy gap of the previous amo");
            last_amo_cyc = cyc;
        end
        last_retire_cyc = cyc;
    endtask

    // sample at the falling edge, outputs are settled there
    always @(negedge clk) begin
        if (started) begin
            for (int k = 0; k < NUM_LANES; k++) begin
                if (retire[k].valid) begin
                    check_retire(retire[k]);
                end
            end
            // independent pairs leave together
            foreach (pair_pcs[i]) begin
                if (retire[0].valid && retire[0].pc == pair_pcs[i]) begin
                    assert (retire[1].valid) else value_error("retire_o[1].valid", 1, 0);
                end
            end
            // dependent lane 1 never retires with its producer
            if (retire[0].valid && retire[0].pc == RAW_PC) begin
                assert (!retire[1].valid) else value_error("retire_o[1].valid", 0, 1);
            end
            // irq lands at the next edge, switch to the handler stream
            if (irq_i) begin
                loop_hits = 0;
                loop_pc = 32'h110;
                exp_q = '{32'h100, 32'h104, 32'h108, 32'h10c, 32'h110};
            end
        end
    end

    // fetch is redirected one cycle after the pulse
    assert property (@(posedge clk) disable iff (rst_i) irq_i |=> (fetch_addr_o == TRAP_VEC))
        else value_error("fetch_addr_o", TRAP_VEC, $sampled(fetch_addr_o));

    task automatic wait_loop_hits(input int target, input int limit, input string what);
        int n;
        n = 0;
        while (loop_hits < target) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                plain_error({"timeout waiting for ", what});
            end
        end
    endtask

    initial begin
        seed = $urandom(69721);
        rst_i = 1'b1;
        irq_i = 1'b0;
        load_program();
        exp_q = '{32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h18, 32'h1c,
                  32'h20, 32'h24, 32'h28, 32'h40, 32'h44, 32'h50, 32'h54, 32'h58};
        loop_pc = 32'h58;
        repeat (4) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        assert (fetch_addr_o == RESET_PC) else value_error("fetch_addr_o", RESET_PC, fetch_addr_o);
        assert (!retire[0].valid && !retire[1].valid)
            else plain_error("retire valid right after reset");
        started = 1;
        wait_loop_hits(2, 300, "the main self loop");
        // irq somewhere inside the loop after the last jump
        irq_delay = $urandom % 8;
        repeat (irq_delay) @(posedge clk);
        @(posedge clk);
        irq_i <= 1'b1;
        @(posedge clk);
        irq_i <= 1'b0;
        wait_loop_hits(3, 300, "the trap handler loop");
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- project.f
verilog/core_cfg_pkg.sv
verilog/pipe_ctrl_pkg.sv
verilog/ifu.sv
verilog/id_lane.sv
verilog/hdu.sv
verilog/ctrl.sv
verilog/ex_unit.sv
verilog/dual_issue_frontend.sv
tests/tb_frontend.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frontend -f project.f -o sim_frontend

output="$(./obj_dir/sim_frontend 2>&1)" || true
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
